/* hw/i2c_pkg.sv */
package i2c_pkg;

	// register byte offsets on the host bus
	localparam logic [4:0] REG_NBY = 5'd0;
	localparam logic [4:0] REG_ADR = 5'd4;
	localparam logic [4:0] REG_RDR = 5'd8;
	localparam logic [4:0] REG_TDR = 5'd12;
	localparam logic [4:0] REG_CFG = 5'd16;

	// configuration register bits
	localparam int CFG_GO_WR = 0;
	localparam int CFG_GO_RD = 1;
	localparam int CFG_DONE  = 2;
	localparam int CFG_NACK  = 3;

	// longest transfer, one byte per lane of a data register
	localparam logic [2:0] MAX_BYTES = 3'd4;

	// byte lane within the 32-bit data registers
	typedef logic [1:0] byte_idx_t;

endpackage

/* hw/i2c_reg_file.sv */
`timescale 1ns/10ps

module i2c_reg_file (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               write_i,
	input  logic [3:0]         data_be_i,
	input  logic [4:0]         addr_i,
	input  logic [31:0]        wdata_i,
	input  logic               rx_we_i,
	input  i2c_pkg::byte_idx_t rx_idx_i,
	input  logic [7:0]         rx_byte_i,
	input  logic               done_i,
	input  logic               nack_i,
	output logic [31:0]        rdata_o,
	output logic [31:0]        nby_o,
	output logic [6:0]         slave_addr_o,
	output logic [31:0]        tx_data_o,
	output logic               go_wr_o,
	output logic               go_rd_o
);
	import i2c_pkg::*;

	logic [31:0] nby_q;
	logic [31:0] adr_q;
	logic [31:0] rdr_q;
	logic [31:0] tdr_q;
	logic [3:0]  cfg_q;

	logic wr_nby;
	logic wr_adr;
	logic wr_rdr;
	logic wr_tdr;
	logic wr_cfg;

	// replace the enabled byte lanes of a register
	function automatic logic [31:0] be_merge(
		input logic [31:0] old_val,
		input logic [31:0] new_val,
		input logic [3:0]  be
	);
		logic [31:0] res;
		res = old_val;
		for (int i = 0; i < int'(MAX_BYTES); i++) begin
			if (be[i]) begin
				res[8*i +: 8] = new_val[8*i +: 8];
			end
		end
		return res;
	endfunction

	assign wr_nby = write_i && (addr_i == REG_NBY);
	assign wr_adr = write_i && (addr_i == REG_ADR);
	assign wr_rdr = write_i && (addr_i == REG_RDR);
	assign wr_tdr = write_i && (addr_i == REG_TDR);
	assign wr_cfg = write_i && (addr_i == REG_CFG);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			nby_q <= '0;
			adr_q <= '0;
			rdr_q <= '0;
			tdr_q <= '0;
			cfg_q <= '0;
		end else begin
			if (wr_nby) begin
				nby_q <= be_merge(nby_q, wdata_i, data_be_i);
			end
			if (wr_adr) begin
				adr_q <= be_merge(adr_q, wdata_i, data_be_i);
			end
			if (wr_tdr) begin
				tdr_q <= be_merge(tdr_q, wdata_i, data_be_i);
			end
			if (wr_rdr) begin
				rdr_q <= be_merge(rdr_q, wdata_i, data_be_i);
			end
			// a received byte lands after any host write to the same register
			if (rx_we_i) begin
				rdr_q[{rx_idx_i, 3'b000} +: 8] <= rx_byte_i;
			end
			// status from the controller wins over a host write
			if (done_i) begin
				cfg_q[CFG_GO_WR] <= 1'b0;
				cfg_q[CFG_GO_RD] <= 1'b0;
				cfg_q[CFG_DONE]  <= 1'b1;
				cfg_q[CFG_NACK]  <= nack_i;
			end else if (wr_cfg && data_be_i[0]) begin
				cfg_q <= wdata_i[3:0];
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rdata_o <= '0;
		end else begin
			case (addr_i)
				REG_NBY: rdata_o <= nby_q;
				REG_ADR: rdata_o <= adr_q;
				REG_RDR: rdata_o <= rdr_q;
				REG_TDR: rdata_o <= tdr_q;
				REG_CFG: rdata_o <= {28'b0, cfg_q};
				default: rdata_o <= '0;
			endcase
		end
	end

	assign nby_o        = nby_q;
	assign slave_addr_o = adr_q[6:0];
	assign tx_data_o    = tdr_q;
	assign go_wr_o      = cfg_q[CFG_GO_WR];
	assign go_rd_o      = cfg_q[CFG_GO_RD];

endmodule

/* hw/i2c_scl_gen.sv */
`timescale 1ns/10ps

module i2c_scl_gen #(
	parameter int CLK_DIV = 16
) (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       run_i,
	output logic       phase_stb_o,
	output logic [1:0] phase_o,
	output logic       scl_drive_low_o
);

	localparam int CW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	logic [CW-1:0] div_q;
	logic [1:0]    phase_q;
	logic          stb_q;
	logic          wrap;

	assign wrap = (div_q == CW'(CLK_DIV - 1));

	// the divider never stops, start and stop conditions need strobes too
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			div_q   <= '0;
			phase_q <= 2'd0;
			stb_q   <= 1'b0;
		end else begin
			stb_q <= wrap;
			if (wrap) begin
				div_q <= '0;
			end else begin
				div_q <= div_q + 1'b1;
			end
			if (!run_i) begin
				phase_q <= 2'd0;
			end else if (wrap) begin
				phase_q <= phase_q + 2'd1;
			end
		end
	end

	// strobe marks entry into the quarter held in phase_q
	assign phase_stb_o     = stb_q;
	assign phase_o         = phase_q;
	assign scl_drive_low_o = run_i && ((phase_q == 2'd0) || (phase_q == 2'd3));

endmodule

/* hw/i2c_xfer_ctrl.sv */
`timescale 1ns/10ps

module i2c_xfer_ctrl (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic [31:0]        nby_i,
	input  logic [6:0]         slave_addr_i,
	input  logic [31:0]        tx_data_i,
	input  logic               go_wr_i,
	input  logic               go_rd_i,
	input  logic               phase_stb_i,
	input  logic [1:0]         phase_i,
	input  logic               sda_i,
	output logic               run_o,
	output logic               sda_drive_low_o,
	output logic               rx_we_o,
	output i2c_pkg::byte_idx_t rx_idx_o,
	output logic [7:0]         rx_byte_o,
	output logic               done_o,
	output logic               nack_o,
	output logic               busy_o
);
	import i2c_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_ADDR,
		ST_ADDR_ACK,
		ST_WRITE,
		ST_READ,
		ST_DATA_ACK,
		ST_STOP
	} state_t;

	state_t    state_q;
	logic [1:0] step_q;
	logic [2:0] bit_cnt_q;
	byte_idx_t byte_q;
	logic      read_q;
	logic [7:0] shift_q;
	logic      sda_smp_q;
	logic      sda_low_q;
	logic      run_q;
	logic      nack_q;

	byte_idx_t  last_idx;
	byte_idx_t  next_idx;
	logic [7:0] tx_byte_cur;
	logic [7:0] tx_byte_next;
	logic       bit_sda_low;
	logic       stb_zero;
	logic       stb_rise;
	logic       stb_sample;
	logic       stb_fall;

	assign stb_zero   = phase_stb_i && (phase_i == 2'd0);
	assign stb_rise   = phase_stb_i && (phase_i == 2'd1);
	assign stb_sample = phase_stb_i && (phase_i == 2'd2);
	assign stb_fall   = phase_stb_i && (phase_i == 2'd3);

	// lane of the first byte, count of 0 acts as 1 and above 4 as 4
	always_comb begin
		if (nby_i == '0) begin
			last_idx = '0;
		end else if (nby_i > {29'b0, MAX_BYTES}) begin
			last_idx = byte_idx_t'(MAX_BYTES - 3'd1);
		end else begin
			last_idx = nby_i[1:0] - 2'd1;
		end
	end

	assign next_idx     = byte_q - 2'd1;
	assign tx_byte_cur  = tx_data_i[{byte_q, 3'b000} +: 8];
	assign tx_byte_next = tx_data_i[{next_idx, 3'b000} +: 8];

	// level wanted on SDA during the low quarter of a bit
	always_comb begin
		case (state_q)
			ST_ADDR,
			ST_WRITE:    bit_sda_low = ~shift_q[7];
			// master acks every read byte but the last
			ST_DATA_ACK: bit_sda_low = read_q && (byte_q != '0);
			default:     bit_sda_low = 1'b0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q   <= ST_IDLE;
			step_q    <= 2'd0;
			bit_cnt_q <= 3'd0;
			byte_q    <= '0;
			read_q    <= 1'b0;
			shift_q   <= '0;
			sda_smp_q <= 1'b0;
			sda_low_q <= 1'b0;
			run_q     <= 1'b0;
			nack_q    <= 1'b0;
		end else begin
			if (stb_sample) begin
				sda_smp_q <= sda_i;
			end
			// bit states update SDA while SCL is low
			if (run_q && (phase_i == 2'd0) && (state_q != ST_STOP)) begin
				sda_low_q <= bit_sda_low;
			end

			case (state_q)
				ST_IDLE: begin
					if (go_wr_i || go_rd_i) begin
						state_q <= ST_START;
						step_q  <= 2'd0;
						read_q  <= !go_wr_i;
						byte_q  <= last_idx;
						nack_q  <= 1'b0;
					end
				end
				ST_START: begin
					if (phase_stb_i) begin
						if (step_q == 2'd0) begin
							// SDA falls with SCL still released
							sda_low_q <= 1'b1;
							step_q    <= 2'd1;
						end else begin
							run_q     <= 1'b1;
							shift_q   <= {slave_addr_i, read_q};
							bit_cnt_q <= 3'd7;
							state_q   <= ST_ADDR;
						end
					end
				end
				ST_ADDR,
				ST_WRITE: begin
					if (stb_fall) begin
						shift_q   <= {shift_q[6:0], 1'b0};
						bit_cnt_q <= bit_cnt_q - 3'd1;
						if (bit_cnt_q == 3'd0) begin
							state_q <= (state_q == ST_ADDR) ? ST_ADDR_ACK : ST_DATA_ACK;
						end
					end
				end
				ST_ADDR_ACK: begin
					if (stb_fall) begin
						bit_cnt_q <= 3'd7;
						if (sda_smp_q) begin
							nack_q  <= 1'b1;
							step_q  <= 2'd0;
							state_q <= ST_STOP;
						end else if (read_q) begin
							state_q <= ST_READ;
						end else begin
							shift_q <= tx_byte_cur;
							state_q <= ST_WRITE;
						end
					end
				end
				ST_READ: begin
					if (stb_sample) begin
						shift_q <= {shift_q[6:0], sda_i};
					end
					if (stb_fall) begin
						bit_cnt_q <= bit_cnt_q - 3'd1;
						if (bit_cnt_q == 3'd0) begin
							state_q <= ST_DATA_ACK;
						end
					end
				end
				ST_DATA_ACK: begin
					if (stb_fall) begin
						bit_cnt_q <= 3'd7;
						if (byte_q == '0) begin
							// nack on the last written byte is fine
							step_q  <= 2'd0;
							state_q <= ST_STOP;
						end else if (!read_q && sda_smp_q) begin
							nack_q  <= 1'b1;
							step_q  <= 2'd0;
							state_q <= ST_STOP;
						end else begin
							byte_q <= next_idx;
							if (read_q) begin
								state_q <= ST_READ;
							end else begin
								shift_q <= tx_byte_next;
								state_q <= ST_WRITE;
							end
						end
					end
				end
				ST_STOP: begin
					case (step_q)
						2'd0: begin
							if (stb_zero) begin
								sda_low_q <= 1'b1;
								step_q    <= 2'd1;
							end
						end
						2'd1: begin
							// SCL has just risen, keep it released from now on
							if (stb_rise) begin
								run_q  <= 1'b0;
								step_q <= 2'd2;
							end
						end
						2'd2: begin
							if (phase_stb_i) begin
								sda_low_q <= 1'b0;
								step_q    <= 2'd3;
							end
						end
						default: begin
							// one quarter of bus free time before done
							if (phase_stb_i) begin
								state_q <= ST_IDLE;
							end
						end
					endcase
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	assign rx_we_o         = (state_q == ST_READ) && stb_fall && (bit_cnt_q == 3'd0);
	assign rx_idx_o        = byte_q;
	assign rx_byte_o       = shift_q;
	assign done_o          = (state_q == ST_STOP) && (step_q == 2'd3) && phase_stb_i;
	assign nack_o          = nack_q;
	assign busy_o          = (state_q != ST_IDLE);
	assign run_o           = run_q;
	assign sda_drive_low_o = sda_low_q;

endmodule

/* hw/i2c_master_top.sv */
`timescale 1ns/10ps

module i2c_master_top #(
	parameter int CLK_DIV = 16
) (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        write_i,
	input  logic [3:0]  data_be_i,
	input  logic [4:0]  addr_i,
	input  logic [31:0] wdata_i,
	input  logic        sda_i,
	output logic [31:0] rdata_o,
	output logic        scl_o,
	output logic        sda_drive_low_o,
	output logic        busy_o
);
	import i2c_pkg::*;

	logic [31:0] nby;
	logic [6:0]  slave_addr;
	logic [31:0] tx_data;
	logic        go_wr;
	logic        go_rd;
	logic        rx_we;
	byte_idx_t   rx_idx;
	logic [7:0]  rx_byte;
	logic        done;
	logic        nack;
	logic        run;
	logic        phase_stb;
	logic [1:0]  phase;
	logic        scl_drive_low;

	i2c_reg_file u_reg_file (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.write_i      (write_i),
		.data_be_i    (data_be_i),
		.addr_i       (addr_i),
		.wdata_i      (wdata_i),
		.rx_we_i      (rx_we),
		.rx_idx_i     (rx_idx),
		.rx_byte_i    (rx_byte),
		.done_i       (done),
		.nack_i       (nack),
		.rdata_o      (rdata_o),
		.nby_o        (nby),
		.slave_addr_o (slave_addr),
		.tx_data_o    (tx_data),
		.go_wr_o      (go_wr),
		.go_rd_o      (go_rd)
	);

	i2c_scl_gen #(
		.CLK_DIV (CLK_DIV)
	) u_scl_gen (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.run_i           (run),
		.phase_stb_o     (phase_stb),
		.phase_o         (phase),
		.scl_drive_low_o (scl_drive_low)
	);

	i2c_xfer_ctrl u_xfer_ctrl (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.nby_i           (nby),
		.slave_addr_i    (slave_addr),
		.tx_data_i       (tx_data),
		.go_wr_i         (go_wr),
		.go_rd_i         (go_rd),
		.phase_stb_i     (phase_stb),
		.phase_i         (phase),
		.sda_i           (sda_i),
		.run_o           (run),
		.sda_drive_low_o (sda_drive_low_o),
		.rx_we_o         (rx_we),
		.rx_idx_o        (rx_idx),
		.rx_byte_o       (rx_byte),
		.done_o          (done),
		.nack_o          (nack),
		.busy_o          (busy_o)
	);

	// open drain SCL, released line reads high
	assign scl_o = ~scl_drive_low;

endmodule

/* test/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
	parameter int PERIOD_NS  = 8,
	parameter int RST_CYCLES = 5
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

/* test/i2c_slave_model.sv */
`timescale 1ns/10ps

module i2c_slave_model #(
	parameter logic [6:0] SLAVE_ADDR = 7'h2A
) (
	input  logic scl_i,
	input  logic sda_i,
	output logic sda_drive_low_o
);

	localparam int M_IDLE = 0;
	localparam int M_ADDR = 1;
	localparam int M_WR   = 2;
	localparam int M_RD   = 3;

	int         mode;
	int         bit_cnt;
	int         rd_ptr;
	int         rx_count;
	integer     seed;
	logic       is_read;
	logic       master_ack;
	logic [7:0] shift;
	logic [7:0] cur;
	logic [7:0] rd_buf [0:3];
	logic [7:0] rx_log [0:15];

	initial begin
		seed = 29738;
		for (int i = 0; i < 4; i++) begin
			rd_buf[i] = $random(seed);
		end
		mode            = M_IDLE;
		bit_cnt         = 0;
		rd_ptr          = 0;
		rx_count        = 0;
		is_read         = 1'b0;
		master_ack      = 1'b0;
		shift           = '0;
		cur             = '0;
		sda_drive_low_o = 1'b0;
	end

	task automatic clear_log();
		rx_count = 0;
	endtask

	// start condition, the next SCL fall opens bit 0
	always @(negedge sda_i) begin
		if (scl_i === 1'b1) begin
			mode            = M_ADDR;
			bit_cnt         = -1;
			rd_ptr          = 0;
			sda_drive_low_o = 1'b0;
		end
	end

	// stop condition
	always @(posedge sda_i) begin
		if (scl_i === 1'b1) begin
			mode            = M_IDLE;
			sda_drive_low_o = 1'b0;
		end
	end

	always @(posedge scl_i) begin
		if (mode != M_IDLE) begin
			if (bit_cnt < 8) begin
				if (mode != M_RD) begin
					shift = {shift[6:0], sda_i};
				end
			end else if (mode == M_RD) begin
				master_ack = (sda_i == 1'b0);
			end
		end
	end

	always @(negedge scl_i) begin
		if (mode != M_IDLE) begin
			if (bit_cnt < 8) begin
				bit_cnt++;
				if (bit_cnt == 8) begin
					// ack slot begins
					if (mode == M_ADDR) begin
						if (shift[7:1] == SLAVE_ADDR) begin
							is_read         = shift[0];
							sda_drive_low_o = 1'b1;
						end else begin
							mode            = M_IDLE;
							sda_drive_low_o = 1'b0;
						end
					end else if (mode == M_WR) begin
						if (rx_count < 16) begin
							rx_log[rx_count] = shift;
							rx_count++;
						end
						sda_drive_low_o = 1'b1;
					end else begin
						sda_drive_low_o = 1'b0;
					end
				end else if (mode == M_RD && bit_cnt > 0) begin
					sda_drive_low_o = ~cur[7 - bit_cnt];
				end
			end else begin
				bit_cnt         = 0;
				sda_drive_low_o = 1'b0;
				if (mode == M_ADDR) begin
					if (is_read) begin
						mode            = M_RD;
						cur             = rd_buf[0];
						sda_drive_low_o = ~cur[7];
					end else begin
						mode = M_WR;
					end
				end else if (mode == M_RD) begin
					rd_ptr++;
					if (master_ack && rd_ptr < 4) begin
						cur             = rd_buf[rd_ptr];
						sda_drive_low_o = ~cur[7];
					end else begin
						mode = M_IDLE;
					end
				end
			end
		end
	end

endmodule

/* test/i2c_assertions.sv */
`timescale 1ns/10ps

module i2c_assertions (
	input logic clk_i,
	input logic rst_i,
	input logic scl_i,
	input logic sda_i,
	input logic sda_drive_low_i,
	input logic busy_i
);

	// an SDA edge with SCL high is a START or STOP, only inside a transfer
	assert property (@(posedge clk_i) disable iff (rst_i)
		(scl_i && $past(scl_i) && (sda_i !== $past(sda_i))) |-> busy_i)
		else $error("SDA changed while SCL high outside a transfer");

	assert property (@(posedge clk_i) $fell(rst_i) |-> (scl_i && !sda_drive_low_i))
		else $error("bus lines not released after reset");

	assert property (@(posedge clk_i) disable iff (rst_i)
		$fell(busy_i) |-> (scl_i && $past(scl_i)))
		else $error("busy fell while SCL was not released");

endmodule

bind i2c_master_top i2c_assertions u_assertions (
	.clk_i           (clk_i),
	.rst_i           (rst_i),
	.scl_i           (scl_o),
	.sda_i           (sda_i),
	.sda_drive_low_i (sda_drive_low_o),
	.busy_i          (busy_o)
);

/* test/tb_i2c_master.sv */
`timescale 1ns/10ps

module tb_i2c_master;
	import i2c_pkg::*;

	localparam int         CLK_DIV    = 4;
	localparam int         CLK_NS     = 8;
	localparam logic [6:0] SLAVE_ADDR = 7'h2A;
	// longest transfer in ns with start and stop overhead
	localparam int XFER_NS     = (9 * (1 + int'(MAX_BYTES)) + 6) * 4 * CLK_DIV * CLK_NS;
	localparam int WATCHDOG_NS = 200 * XFER_NS;

	logic        clk;
	logic        rst;
	logic        write;
	logic [3:0]  data_be;
	logic [4:0]  addr;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic        scl;
	logic        dut_sda_low;
	logic        slave_sda_low;
	logic        sda_line;
	logic        busy;

	logic [31:0] got_q [$];
	logic [31:0] exp_q [$];
	string       msg_q [$];
	integer      seed;

	// wired-AND with pull-up
	assign sda_line = !(dut_sda_low || slave_sda_low);

	tb_clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(5)) u_clk_gen (.clk_o(clk), .rst_o(rst));

	i2c_master_top #(.CLK_DIV(CLK_DIV)) u_i2c_master_top (
		.clk_i           (clk),
		.rst_i           (rst),
		.write_i         (write),
		.data_be_i       (data_be),
		.addr_i          (addr),
		.wdata_i         (wdata),
		.sda_i           (sda_line),
		.rdata_o         (rdata),
		.scl_o           (scl),
		.sda_drive_low_o (dut_sda_low),
		.busy_o          (busy)
	);

	i2c_slave_model #(.SLAVE_ADDR(SLAVE_ADDR)) u_slave (
		.scl_i           (scl),
		.sda_i           (sda_line),
		.sda_drive_low_o (slave_sda_low)
	);

	// expected slave bytes (in arrival order), receive register and status
	function automatic void ref_transfer(
		input  logic        is_read,
		input  logic [31:0] nby,
		input  logic [6:0]  dev_addr,
		input  logic [31:0] tx,
		input  logic [31:0] rdr_old,
		input  logic [31:0] rd_seq,
		output int          exp_count,
		output logic [31:0] exp_bytes,
		output logic [31:0] exp_rdr,
		output logic [3:0]  exp_cfg
	);
		int n;
		n = (nby == 0) ? 1 : ((nby > MAX_BYTES) ? int'(MAX_BYTES) : int'(nby));
		exp_count = 0;
		exp_bytes = '0;
		exp_rdr   = rdr_old;
		exp_cfg   = '0;
		exp_cfg[CFG_DONE] = 1'b1;
		if (dev_addr != SLAVE_ADDR) begin
			exp_cfg[CFG_NACK] = 1'b1;
		end else if (!is_read) begin
			exp_count = n;
			for (int k = 0; k < n; k++) begin
				exp_bytes[8*k +: 8] = tx[8*(n-1-k) +: 8];
			end
		end else begin
			for (int k = 0; k < n; k++) begin
				exp_rdr[8*(n-1-k) +: 8] = rd_seq[8*k +: 8];
			end
		end
	endfunction

	task automatic push_check(input logic [31:0] got, input logic [31:0] exp, input string msg);
		got_q.push_back(got);
		exp_q.push_back(exp);
		msg_q.push_back(msg);
	endtask

	task automatic bus_write(input logic [4:0] a, input logic [31:0] d, input logic [3:0] be);
		@(posedge clk);
		write   <= 1'b1;
		addr    <= a;
		wdata   <= d;
		data_be <= be;
		@(posedge clk);
		write   <= 1'b0;
		data_be <= 4'h0;
	endtask

	task automatic bus_read(input logic [4:0] a, output logic [31:0] d);
		@(posedge clk);
		addr <= a;
		@(posedge clk);
		@(negedge clk);
		d = rdata;
	endtask

	task automatic wait_transfer(input string name);
		int rise_cycles;
		rise_cycles = 0;
		do begin
			@(negedge clk);
			rise_cycles++;
		end while (!busy);
		// go lands at the write edge and busy follows one edge later
		push_check(rise_cycles, 32'd2, {name, " cycles from go to busy"});
		do @(negedge clk); while (busy);
	endtask

	task automatic merge_check(input logic [4:0] a, input logic [31:0] init,
		input logic [31:0] d, input logic [3:0] be);
		logic [31:0] exp;
		logic [31:0] got;
		exp = init;
		for (int i = 0; i < 4; i++) begin
			if (be[i]) begin
				exp[8*i +: 8] = d[8*i +: 8];
			end
		end
		bus_write(a, init, 4'hF);
		bus_write(a, d, be);
		bus_read(a, got);
		push_check(got, exp, $sformatf("merged write at offset %0d", a));
	endtask

	task automatic run_transfer(input logic is_read, input logic [31:0] nby,
		input logic [6:0] dev_addr, input logic [31:0] tx, input logic [31:0] rdr_pre,
		input string name);
		logic [31:0] exp_bytes;
		logic [31:0] exp_rdr;
		logic [31:0] got_rdr;
		logic [31:0] got_cfg;
		logic [31:0] rd_seq;
		logic [3:0]  exp_cfg;
		logic [3:0]  go;
		int          exp_count;
		bus_write(REG_NBY, nby, 4'hF);
		bus_write(REG_ADR, {25'b0, dev_addr}, 4'hF);
		bus_write(REG_TDR, tx, 4'hF);
		bus_write(REG_RDR, rdr_pre, 4'hF);
		u_slave.clear_log();
		go = '0;
		go[is_read ? CFG_GO_RD : CFG_GO_WR] = 1'b1;
		bus_write(REG_CFG, {28'b0, go}, 4'hF);
		wait_transfer(name);
		bus_read(REG_CFG, got_cfg);
		bus_read(REG_RDR, got_rdr);
		for (int k = 0; k < 4; k++) begin
			rd_seq[8*k +: 8] = u_slave.rd_buf[k];
		end
		ref_transfer(is_read, nby, dev_addr, tx, rdr_pre, rd_seq,
			exp_count, exp_bytes, exp_rdr, exp_cfg);
		push_check(got_cfg, {28'b0, exp_cfg}, {name, " status"});
		push_check(got_rdr, exp_rdr, {name, " receive register"});
		push_check(u_slave.rx_count, exp_count, {name, " slave byte count"});
		for (int k = 0; k < exp_count; k++) begin
			push_check({24'b0, u_slave.rx_log[k]}, {24'b0, exp_bytes[8*k +: 8]},
				$sformatf("%s slave byte %0d", name, k));
		end
	endtask

	// compare queued results
	initial begin
		logic [31:0] got_v;
		logic [31:0] exp_v;
		string       msg_v;
		forever begin
			@(negedge clk);
			while (got_q.size() > 0) begin
				got_v = got_q.pop_front();
				exp_v = exp_q.pop_front();
				msg_v = msg_q.pop_front();
				assert (got_v === exp_v) else begin
					$display("CHECK FAILED at %0t ns: %s, got %h expected %h",
						$time, msg_v, got_v, exp_v);
					$display("SOME TESTS FAILED");
					$fatal(1, "stopping at first mismatch");
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the simulation ran too long and was stopped");
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [31:0] rd;
		logic [31:0] nby_r;
		logic [6:0]  adr_r;
		logic        dir_r;
		write   = 1'b0;
		data_be = 4'h0;
		addr    = '0;
		wdata   = '0;
		seed    = 29738;
		wait (rst == 1'b0);
		@(posedge clk);

		// registers come out of reset cleared
		bus_read(REG_NBY, rd);
		push_check(rd, 32'h0, "byte count after reset");
		bus_read(REG_CFG, rd);
		push_check(rd, 32'h0, "configuration after reset");
		merge_check(REG_NBY, 32'h1122_3344, 32'hA1B2_C3D4, 4'b0101);
		merge_check(REG_ADR, 32'h5566_7788, 32'h0F1E_2D3C, 4'b1010);
		merge_check(REG_TDR, 32'h99AA_BBCC, 32'h1357_9BDF, 4'b0110);
		merge_check(REG_RDR, 32'hCAFE_F00D, 32'h2468_ACE0, 4'b1001);

		run_transfer(1'b0, 32'd1, SLAVE_ADDR, 32'h8C3A_F1E7, 32'h0, "write 1");
		run_transfer(1'b0, 32'd2, SLAVE_ADDR, 32'h4D21_9B06, 32'h0, "write 2");
		run_transfer(1'b0, 32'd3, SLAVE_ADDR, 32'hE57C_0A93, 32'h0, "write 3");
		run_transfer(1'b0, 32'd4, SLAVE_ADDR, 32'h36F0_C85B, 32'h0, "write 4");
		run_transfer(1'b0, 32'd0, SLAVE_ADDR, 32'h7A1D_44E2, 32'h0, "write count 0");
		run_transfer(1'b0, 32'd7, SLAVE_ADDR, 32'h0B9F_63D8, 32'h0, "write count 7");
		for (int n = 1; n <= 4; n++) begin
			run_transfer(1'b1, n, SLAVE_ADDR, 32'h0, 32'hDEAD_BEEF, $sformatf("read %0d", n));
		end
		run_transfer(1'b0, 32'd2, 7'h2B, 32'h1234_5678, 32'h0, "write wrong address");
		run_transfer(1'b1, 32'd3, 7'h15, 32'h0, 32'h5A5A_A5A5, "read wrong address");

		for (int t = 0; t < 20; t++) begin
			dir_r = $random(seed);
			nby_r = $unsigned($random(seed)) % 8;
			adr_r = (($random(seed) & 7) == 0) ? 7'h55 : SLAVE_ADDR;
			run_transfer(dir_r, nby_r, adr_r, $random(seed), $random(seed),
				$sformatf("random %0d", t));
		end

		repeat (4) @(negedge clk);
		if (got_q.size() == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("SOME TESTS FAILED");
			$fatal(1, "checks failed");
		end
	end

endmodule

/* tb.f */
hw/i2c_pkg.sv
hw/i2c_reg_file.sv
hw/i2c_scl_gen.sv
hw/i2c_xfer_ctrl.sv
hw/i2c_master_top.sv
test/tb_clk_gen.sv
test/i2c_slave_model.sv
test/i2c_assertions.sv
test/tb_i2c_master.sv
